// ==== design/commit_pkg.sv ====
// Commit path definitions
package commit_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    // Data and address width of the retiring stream
    localparam int unsigned XLEN = 32;

    // ----------------------------------------
    // Flush window
    // ----------------------------------------

    // Cycles flush stays asserted before the redirect
    localparam int unsigned FLUSH_CYCLES = 4;

    // Counter width able to hold the full window
    localparam int unsigned FLUSH_CNT_W = $clog2(FLUSH_CYCLES + 1);

    // Load value for the flush down-counter
    localparam logic [FLUSH_CNT_W-1:0] FLUSH_LOAD = FLUSH_CNT_W'(FLUSH_CYCLES);

    // ----------------------------------------
    // Operations
    // ----------------------------------------

    // What a retiring instruction asks of the commit stage
    typedef enum logic [1:0] {
        // Plain retire, no side effect besides counting
        OP_NONE      = 2'd0,
        // Read the addressed CSR
        OP_CSR_READ  = 2'd1,
        // Write the addressed CSR
        OP_CSR_WRITE = 2'd2,
        // Return from trap, redirect to mepc
        OP_ERET      = 2'd3
    } commit_op_e;

endpackage

// ==== design/csr_pkg.sv ====
// Machine CSR definitions
package csr_pkg;

    // ----------------------------------------
    // Addresses
    // ----------------------------------------

    localparam int unsigned CSR_ADDR_W = 12;

    // Machine trap handling
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;

    // Counters, read only from the commit stream
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEXCNT   = 12'hB03;

    // ----------------------------------------
    // Exception causes
    // ----------------------------------------

    localparam int unsigned CAUSE_W = 4;

    // Illegal instruction, also used for bad CSR accesses
    localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL = 4'd2;

    // ----------------------------------------
    // Reset values
    // ----------------------------------------

    // Trap vector out of reset
    localparam logic [31:0] RESET_MTVEC = 32'h0000_0100;

endpackage

// ==== design/commit_ctrl_fsm.sv ====
// Commit controller
`timescale 1ns/100ps

module commit_ctrl_fsm (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    // Incoming commit request
    input  logic                         commit_valid_i,
    input  commit_pkg::commit_op_e       commit_op_i,
    input  logic                         commit_ex_valid_i,
    input  logic [csr_pkg::CAUSE_W-1:0]  commit_ex_cause_i,
    output logic                         commit_ready_o,
    // CSR file side
    input  logic                         csr_illegal_i,
    output logic                         retire_o,
    output logic                         trap_o,
    output logic [csr_pkg::CAUSE_W-1:0]  trap_cause_o,
    input  logic [commit_pkg::XLEN-1:0]  mtvec_i,
    input  logic [commit_pkg::XLEN-1:0]  mepc_i,
    // Flush timer
    output logic                         timer_start_o,
    input  logic                         timer_done_i,
    // Pipeline control
    output logic                         flush_o,
    output logic                         set_pc_o,
    output logic [commit_pkg::XLEN-1:0]  next_pc_o
);

    typedef enum logic [1:0] {
        RUN,
        FLUSH,
        REDIRECT
    } state_e;

    state_e                      state_q;
    state_e                      state_d;
    logic                        accept;
    logic                        take_trap;
    logic                        take_eret;
    logic [commit_pkg::XLEN-1:0] target_q;

    // ----------------------------------------
    // Acceptance and trap decision
    // ----------------------------------------

    // Only take new work while running
    assign commit_ready_o = (state_q == RUN);
    assign accept         = commit_valid_i & commit_ready_o;

    // Upstream exception wins over a bad CSR access
    assign take_trap = accept & (commit_ex_valid_i | csr_illegal_i);
    assign take_eret = accept & ~take_trap & (commit_op_i == commit_pkg::OP_ERET);

    assign retire_o      = accept & ~take_trap;
    assign trap_o        = take_trap;
    assign trap_cause_o  = commit_ex_valid_i ? commit_ex_cause_i : csr_pkg::CAUSE_ILLEGAL;
    assign timer_start_o = take_trap | take_eret;

    // ----------------------------------------
    // State sequencing
    // ----------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            RUN: begin
                if (timer_start_o) begin
                    state_d = FLUSH;
                end
            end
            FLUSH: begin
                // Timer flags the last flush cycle
                if (timer_done_i) begin
                    state_d = REDIRECT;
                end
            end
            REDIRECT: state_d = RUN;
            default:  state_d = RUN;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // Redirect target, sampled when the flush starts
    always_ff @(posedge clk_i) begin
        if (take_trap) begin
            target_q <= mtvec_i;
        end else if (take_eret) begin
            target_q <= mepc_i;
        end
    end

    assign flush_o   = (state_q == FLUSH);
    assign set_pc_o  = (state_q == REDIRECT);
    assign next_pc_o = target_q;

endmodule

// ==== design/flush_timer.sv ====
// Flush window timer
`timescale 1ns/100ps

module flush_timer (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic start_i,
    output logic done_o
);

    logic [commit_pkg::FLUSH_CNT_W-1:0] count_q;

    // Load the full window on start, then count down and park at zero
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (start_i) begin
            count_q <= commit_pkg::FLUSH_LOAD;
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    // High while the final count is held, i.e. the last flush cycle
    assign done_o = (count_q == {{(commit_pkg::FLUSH_CNT_W-1){1'b0}}, 1'b1});

endmodule

// ==== design/csr_regfile.sv ====
// Machine CSR file
`timescale 1ns/100ps

module csr_regfile (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    // From the controller
    input  logic                           retire_i,
    input  logic                           trap_i,
    input  commit_pkg::commit_op_e         op_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] addr_i,
    input  logic [commit_pkg::XLEN-1:0]    wdata_i,
    input  logic [commit_pkg::XLEN-1:0]    pc_i,
    input  logic [csr_pkg::CAUSE_W-1:0]    cause_i,
    output logic                           csr_illegal_o,
    // Counter read path
    input  logic [commit_pkg::XLEN-1:0]    cnt_rdata_i,
    // Trap targets
    output logic [commit_pkg::XLEN-1:0]    mtvec_o,
    output logic [commit_pkg::XLEN-1:0]    mepc_o,
    // Read response
    output logic [commit_pkg::XLEN-1:0]    rdata_o,
    output logic                           rdata_valid_o
);

    logic [commit_pkg::XLEN-1:0] mscratch_q;
    logic [commit_pkg::XLEN-1:0] mepc_q;
    logic [commit_pkg::XLEN-1:0] mcause_q;
    logic [commit_pkg::XLEN-1:0] mtvec_q;
    logic [commit_pkg::XLEN-1:0] rdata_mux;
    logic                        addr_known;
    logic                        addr_is_cnt;
    logic                        is_csr_op;
    logic                        csr_we;
    logic                        csr_re;

    // ----------------------------------------
    // Address decode and read mux
    // ----------------------------------------

    always_comb begin
        addr_known  = 1'b1;
        addr_is_cnt = 1'b0;
        rdata_mux   = '0;
        case (addr_i)
            csr_pkg::CSR_MSCRATCH: rdata_mux = mscratch_q;
            csr_pkg::CSR_MEPC:     rdata_mux = mepc_q;
            csr_pkg::CSR_MCAUSE:   rdata_mux = mcause_q;
            csr_pkg::CSR_MTVEC:    rdata_mux = mtvec_q;
            csr_pkg::CSR_MINSTRET,
            csr_pkg::CSR_MEXCNT: begin
                // Counters live in perf_counters
                addr_is_cnt = 1'b1;
                rdata_mux   = cnt_rdata_i;
            end
            default: addr_known = 1'b0;
        endcase
    end

    assign is_csr_op = (op_i == commit_pkg::OP_CSR_READ) | (op_i == commit_pkg::OP_CSR_WRITE);

    // Unknown address, or an attempt to write a counter
    assign csr_illegal_o = is_csr_op &
                           (~addr_known | (addr_is_cnt & (op_i == commit_pkg::OP_CSR_WRITE)));

    // Retire already excludes trapping instructions
    assign csr_we = retire_i & (op_i == commit_pkg::OP_CSR_WRITE);
    assign csr_re = retire_i & (op_i == commit_pkg::OP_CSR_READ);

    // ----------------------------------------
    // Register state
    // ----------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtvec_q    <= csr_pkg::RESET_MTVEC;
        end else if (trap_i) begin
            // Save the faulting pc and its cause
            mepc_q   <= pc_i;
            mcause_q <= {{(commit_pkg::XLEN-csr_pkg::CAUSE_W){1'b0}}, cause_i};
        end else if (csr_we) begin
            case (addr_i)
                csr_pkg::CSR_MSCRATCH: mscratch_q <= wdata_i;
                csr_pkg::CSR_MEPC:     mepc_q     <= wdata_i;
                csr_pkg::CSR_MCAUSE:   mcause_q   <= wdata_i;
                // Vector base is word aligned
                csr_pkg::CSR_MTVEC:    mtvec_q    <= {wdata_i[commit_pkg::XLEN-1:2], 2'b00};
                default: ;
            endcase
        end
    end

    // Read response one cycle after the retire
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_valid_o <= 1'b0;
        end else begin
            rdata_valid_o <= csr_re;
        end
    end

    always_ff @(posedge clk_i) begin
        if (csr_re) begin
            rdata_o <= rdata_mux;
        end
    end

    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;

endmodule

// ==== design/perf_counters.sv ====
// Retire and exception counters
`timescale 1ns/100ps

module perf_counters (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           retire_i,
    input  logic                           trap_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] addr_i,
    output logic [commit_pkg::XLEN-1:0]    cnt_rdata_o
);

    logic [commit_pkg::XLEN-1:0] minstret_q;
    logic [commit_pkg::XLEN-1:0] mexcnt_q;

    // ----------------------------------------
    // Counting
    // ----------------------------------------

    // Same edge as the CSR update, so a read sees the old count
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            minstret_q <= '0;
            mexcnt_q   <= '0;
        end else begin
            if (retire_i) begin
                minstret_q <= minstret_q + 1'b1;
            end
            if (trap_i) begin
                mexcnt_q <= mexcnt_q + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Read select
    // ----------------------------------------

    always_comb begin
        case (addr_i)
            csr_pkg::CSR_MINSTRET: cnt_rdata_o = minstret_q;
            csr_pkg::CSR_MEXCNT:   cnt_rdata_o = mexcnt_q;
            default:               cnt_rdata_o = '0;
        endcase
    end

endmodule

// ==== design/commit_unit.sv ====
// Commit unit top level
`timescale 1ns/100ps

module commit_unit (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    // Commit handshake
    input  logic                           commit_valid_i,
    output logic                           commit_ready_o,
    input  logic [commit_pkg::XLEN-1:0]    commit_pc_i,
    input  commit_pkg::commit_op_e         commit_op_i,
    input  logic                           commit_ex_valid_i,
    input  logic [csr_pkg::CAUSE_W-1:0]    commit_ex_cause_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] commit_csr_addr_i,
    input  logic [commit_pkg::XLEN-1:0]    commit_wdata_i,
    // CSR read response
    output logic [commit_pkg::XLEN-1:0]    csr_rdata_o,
    output logic                           csr_rdata_valid_o,
    // Pipeline control
    output logic                           flush_o,
    output logic                           set_pc_o,
    output logic [commit_pkg::XLEN-1:0]    next_pc_o
);

    logic                        retire;
    logic                        trap;
    logic [csr_pkg::CAUSE_W-1:0] trap_cause;
    logic                        csr_illegal;
    logic [commit_pkg::XLEN-1:0] mtvec;
    logic [commit_pkg::XLEN-1:0] mepc;
    logic [commit_pkg::XLEN-1:0] cnt_rdata;
    logic                        timer_start;
    logic                        timer_done;

    // ----------------------------------------
    // Controller and flush timer
    // ----------------------------------------

    commit_ctrl_fsm i_commit_ctrl_fsm (
        .clk_i             ( clk_i             ),
        .rst_ni            ( rst_ni            ),
        .commit_valid_i    ( commit_valid_i    ),
        .commit_op_i       ( commit_op_i       ),
        .commit_ex_valid_i ( commit_ex_valid_i ),
        .commit_ex_cause_i ( commit_ex_cause_i ),
        .commit_ready_o    ( commit_ready_o    ),
        .csr_illegal_i     ( csr_illegal       ),
        .retire_o          ( retire            ),
        .trap_o            ( trap              ),
        .trap_cause_o      ( trap_cause        ),
        .mtvec_i           ( mtvec             ),
        .mepc_i            ( mepc              ),
        .timer_start_o     ( timer_start       ),
        .timer_done_i      ( timer_done        ),
        .flush_o           ( flush_o           ),
        .set_pc_o          ( set_pc_o          ),
        .next_pc_o         ( next_pc_o         )
    );

    flush_timer i_flush_timer (
        .clk_i   ( clk_i       ),
        .rst_ni  ( rst_ni      ),
        .start_i ( timer_start ),
        .done_o  ( timer_done  )
    );

    // ----------------------------------------
    // CSR file and counters
    // ----------------------------------------

    csr_regfile i_csr_regfile (
        .clk_i         ( clk_i             ),
        .rst_ni        ( rst_ni            ),
        .retire_i      ( retire            ),
        .trap_i        ( trap              ),
        .op_i          ( commit_op_i       ),
        .addr_i        ( commit_csr_addr_i ),
        .wdata_i       ( commit_wdata_i    ),
        .pc_i          ( commit_pc_i       ),
        .cause_i       ( trap_cause        ),
        .csr_illegal_o ( csr_illegal       ),
        .cnt_rdata_i   ( cnt_rdata         ),
        .mtvec_o       ( mtvec             ),
        .mepc_o        ( mepc              ),
        .rdata_o       ( csr_rdata_o       ),
        .rdata_valid_o ( csr_rdata_valid_o )
    );

    perf_counters i_perf_counters (
        .clk_i       ( clk_i             ),
        .rst_ni      ( rst_ni            ),
        .retire_i    ( retire            ),
        .trap_i      ( trap              ),
        .addr_i      ( commit_csr_addr_i ),
        .cnt_rdata_o ( cnt_rdata         )
    );

endmodule

// ==== verif/commit_assertions.sv ====
// Commit handshake assertions
`timescale 1ns/100ps

module commit_assertions (
    input logic                   clk_i,
    input logic                   rst_ni,
    input logic                   valid_i,
    input logic                   ready_i,
    input logic                   flush_i,
    input logic                   set_pc_i,
    input logic                   rdata_valid_i,
    input commit_pkg::commit_op_e op_i
);

    int unsigned flush_run;

    // Cycles spent in the current flush window
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            flush_run <= 0;
        end else if (flush_i) begin
            flush_run <= flush_run + 1;
        end else begin
            flush_run <= 0;
        end
    end

    ready_low_in_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |-> !ready_i)
        else $error("commit_ready_o high while flushing");

    set_pc_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
        set_pc_i |=> !set_pc_i)
        else $error("set_pc_o held longer than one cycle");

    flush_not_too_long: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |-> flush_run < commit_pkg::FLUSH_CYCLES)
        else $error("flush_o held past its window");

    flush_before_set_pc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        set_pc_i |-> flush_run == commit_pkg::FLUSH_CYCLES)
        else $error("set_pc_o without a full flush window");

    // Read data only right after a read crossed the handshake
    rdata_after_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rdata_valid_i |-> $past(valid_i && ready_i && op_i == commit_pkg::OP_CSR_READ))
        else $error("csr_rdata_valid_o without a read");

    // An accepted read either answers or traps into a flush
    read_gets_rdata: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_i && ready_i && op_i == commit_pkg::OP_CSR_READ |=> rdata_valid_i || flush_i)
        else $error("accepted read got no csr_rdata_valid_o");

endmodule

bind commit_unit commit_assertions i_commit_assertions (
    .clk_i         ( clk_i             ),
    .rst_ni        ( rst_ni            ),
    .valid_i       ( commit_valid_i    ),
    .ready_i       ( commit_ready_o    ),
    .flush_i       ( flush_o           ),
    .set_pc_i      ( set_pc_o          ),
    .rdata_valid_i ( csr_rdata_valid_o ),
    .op_i          ( commit_op_i       )
);

// ==== verif/commit_tb.sv ====
// Commit unit testbench
`timescale 1ns/100ps

module commit_tb;

    localparam int WAIT_LIMIT = 50;
    localparam int MIX_COUNT  = 40;
    localparam logic [csr_pkg::CSR_ADDR_W-1:0] ADDR_UNKNOWN = 12'h7C0;

    logic                           clk_i = 1'b0;
    logic                           rst_ni;
    logic                           commit_valid_i;
    logic                           commit_ready_o;
    logic [commit_pkg::XLEN-1:0]    commit_pc_i;
    commit_pkg::commit_op_e         commit_op_i;
    logic                           commit_ex_valid_i;
    logic [csr_pkg::CAUSE_W-1:0]    commit_ex_cause_i;
    logic [csr_pkg::CSR_ADDR_W-1:0] commit_csr_addr_i;
    logic [commit_pkg::XLEN-1:0]    commit_wdata_i;
    logic [commit_pkg::XLEN-1:0]    csr_rdata_o;
    logic                           csr_rdata_valid_o;
    logic                           flush_o;
    logic                           set_pc_o;
    logic [commit_pkg::XLEN-1:0]    next_pc_o;

    // Reference model state
    logic [commit_pkg::XLEN-1:0] ref_mscratch;
    logic [commit_pkg::XLEN-1:0] ref_mepc;
    logic [commit_pkg::XLEN-1:0] ref_mcause;
    logic [commit_pkg::XLEN-1:0] ref_mtvec;
    logic [commit_pkg::XLEN-1:0] ref_minstret;
    logic [commit_pkg::XLEN-1:0] ref_mexcnt;

    logic [commit_pkg::XLEN-1:0] exp_rdata[$];
    logic [commit_pkg::XLEN-1:0] exp_pc[$];
    logic [commit_pkg::XLEN-1:0] pc_next = 32'h0000_1000;
    logic [31:0]                 lfsr_state = 32'hfbf0;
    int                          errors = 0;
    int                          timeouts = 0;
    int                          flush_len = 0;
    logic                        prev_set_pc = 1'b0;
    logic                        reset_checked = 1'b0;
    logic                        ready_due = 1'b1;
    event                        run_end;

    commit_unit uut (
        .clk_i             ( clk_i             ),
        .rst_ni            ( rst_ni            ),
        .commit_valid_i    ( commit_valid_i    ),
        .commit_ready_o    ( commit_ready_o    ),
        .commit_pc_i       ( commit_pc_i       ),
        .commit_op_i       ( commit_op_i       ),
        .commit_ex_valid_i ( commit_ex_valid_i ),
        .commit_ex_cause_i ( commit_ex_cause_i ),
        .commit_csr_addr_i ( commit_csr_addr_i ),
        .commit_wdata_i    ( commit_wdata_i    ),
        .csr_rdata_o       ( csr_rdata_o       ),
        .csr_rdata_valid_o ( csr_rdata_valid_o ),
        .flush_o           ( flush_o           ),
        .set_pc_o          ( set_pc_o          ),
        .next_pc_o         ( next_pc_o         )
    );

    always #4 clk_i = ~clk_i;

    // ----------------------------------------
    // Random source and reference model
    // ----------------------------------------

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    // Retires one instruction in the model, returns 1 when it redirects
    function automatic logic ref_commit(
        input  commit_pkg::commit_op_e         op,
        input  logic                           ex_valid,
        input  logic [csr_pkg::CAUSE_W-1:0]    ex_cause,
        input  logic [csr_pkg::CSR_ADDR_W-1:0] addr,
        input  logic [commit_pkg::XLEN-1:0]    wdata,
        input  logic [commit_pkg::XLEN-1:0]    pc,
        output logic                           has_rdata,
        output logic [commit_pkg::XLEN-1:0]    rdata,
        output logic [commit_pkg::XLEN-1:0]    target
    );
        logic known;
        logic is_cnt;
        logic illegal;
        known  = 1'b1;
        is_cnt = 1'b0;
        rdata  = '0;
        target = '0;
        has_rdata = 1'b0;
        case (addr)
            csr_pkg::CSR_MSCRATCH: rdata = ref_mscratch;
            csr_pkg::CSR_MEPC:     rdata = ref_mepc;
            csr_pkg::CSR_MCAUSE:   rdata = ref_mcause;
            csr_pkg::CSR_MTVEC:    rdata = ref_mtvec;
            csr_pkg::CSR_MINSTRET: begin
                rdata  = ref_minstret;
                is_cnt = 1'b1;
            end
            csr_pkg::CSR_MEXCNT: begin
                rdata  = ref_mexcnt;
                is_cnt = 1'b1;
            end
            default: known = 1'b0;
        endcase
        illegal = (op == commit_pkg::OP_CSR_READ && !known) ||
                  (op == commit_pkg::OP_CSR_WRITE && (!known || is_cnt));
        if (ex_valid || illegal) begin
            ref_mepc   = pc;
            ref_mcause = '0;
            ref_mcause[csr_pkg::CAUSE_W-1:0] = ex_valid ? ex_cause : 4'd2;
            ref_mexcnt = ref_mexcnt + 32'd1;
            target     = ref_mtvec;
            return 1'b1;
        end
        // Read value was taken before this increment
        ref_minstret = ref_minstret + 32'd1;
        has_rdata    = (op == commit_pkg::OP_CSR_READ);
        if (op == commit_pkg::OP_CSR_WRITE) begin
            case (addr)
                csr_pkg::CSR_MSCRATCH: ref_mscratch = wdata;
                csr_pkg::CSR_MEPC:     ref_mepc     = wdata;
                csr_pkg::CSR_MCAUSE:   ref_mcause   = wdata;
                csr_pkg::CSR_MTVEC:    ref_mtvec    = {wdata[31:2], 2'b00};
                default: ;
            endcase
        end
        target = ref_mepc;
        return (op == commit_pkg::OP_ERET);
    endfunction

    // ----------------------------------------
    // Compare tasks and process
    // ----------------------------------------

    task automatic check_data(input string name, input logic [commit_pkg::XLEN-1:0] got,
                              input logic [commit_pkg::XLEN-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (!reset_checked) begin
                check_flag("commit_ready_o", commit_ready_o, 1'b1);
                check_flag("flush_o", flush_o, 1'b0);
                check_flag("set_pc_o", set_pc_o, 1'b0);
                check_flag("csr_rdata_valid_o", csr_rdata_valid_o, 1'b0);
                reset_checked = 1'b1;
            end
            if (csr_rdata_valid_o) begin
                if (exp_rdata.size() == 0) begin
                    $display("Read data came back at %0t with no read outstanding", $time);
                    errors++;
                end else begin
                    check_data("csr_rdata_o", csr_rdata_o, exp_rdata.pop_front());
                end
            end
            if (flush_o || set_pc_o) begin
                check_flag("commit_ready_o", commit_ready_o, 1'b0);
            end
            // Ready returns right after the redirect
            if (prev_set_pc) begin
                check_flag("commit_ready_o", commit_ready_o, 1'b1);
            end
            if (set_pc_o) begin
                if (flush_len != commit_pkg::FLUSH_CYCLES) begin
                    $display("Flush lasted %0d cycles before the redirect at %0t",
                             flush_len, $time);
                    errors++;
                end
                if (exp_pc.size() == 0) begin
                    $display("Redirect at %0t with no trap or eret outstanding", $time);
                    errors++;
                end else begin
                    check_data("next_pc_o", next_pc_o, exp_pc.pop_front());
                end
                flush_len = 0;
            end else if (flush_o) begin
                flush_len++;
            end
            prev_set_pc = set_pc_o;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    // Holds the request until accepted, called on a falling edge
    task automatic commit_instr(input commit_pkg::commit_op_e op, input logic ex_valid,
                                input logic [csr_pkg::CAUSE_W-1:0] cause,
                                input logic [csr_pkg::CSR_ADDR_W-1:0] addr,
                                input logic [commit_pkg::XLEN-1:0] wdata);
        int                          waited;
        logic                        redirect;
        logic                        has_rd;
        logic [commit_pkg::XLEN-1:0] rd;
        logic [commit_pkg::XLEN-1:0] tgt;
        commit_valid_i    = 1'b1;
        commit_pc_i       = pc_next;
        commit_op_i       = op;
        commit_ex_valid_i = ex_valid;
        commit_ex_cause_i = cause;
        commit_csr_addr_i = addr;
        commit_wdata_i    = wdata;
        pc_next           = pc_next + 32'd4;
        // Without a redirect in progress the stage takes one per cycle
        if (ready_due) begin
            check_flag("commit_ready_o", commit_ready_o, 1'b1);
        end
        waited            = 0;
        while (!commit_ready_o && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!commit_ready_o) begin
            $display("Timed out at %0t waiting for commit_ready_o", $time);
            timeouts++;
            -> run_end;
        end else begin
            redirect = ref_commit(op, ex_valid, cause, addr, wdata, commit_pc_i,
                                  has_rd, rd, tgt);
            if (has_rd) begin
                exp_rdata.push_back(rd);
            end
            if (redirect) begin
                exp_pc.push_back(tgt);
            end
            ready_due = !redirect;
        end
        @(negedge clk_i);
        commit_valid_i = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk_i);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_rdata.size() != 0 || exp_pc.size() != 0) && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (exp_rdata.size() != 0 || exp_pc.size() != 0) begin
            $display("Timed out at %0t waiting for read data or a redirect", $time);
            timeouts++;
            -> run_end;
        end
    endtask

    initial begin
        logic [31:0] r;
        rst_ni            = 1'b0;
        commit_valid_i    = 1'b0;
        commit_pc_i       = '0;
        commit_op_i       = commit_pkg::OP_NONE;
        commit_ex_valid_i = 1'b0;
        commit_ex_cause_i = '0;
        commit_csr_addr_i = '0;
        commit_wdata_i    = '0;
        ref_mscratch      = '0;
        ref_mepc          = '0;
        ref_mcause        = '0;
        ref_mtvec         = csr_pkg::RESET_MTVEC;
        ref_minstret      = '0;
        ref_mexcnt        = '0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        // Reset values
        commit_instr(commit_pkg::OP_CSR_READ, 1'b0, '0, csr_pkg::CSR_MINSTRET, '0);
        commit_instr(commit_pkg::OP_CSR_READ, 1'b0, '0, csr_pkg::CSR_MEXCNT, '0);
        commit_instr(commit_pkg::OP_CSR_READ, 1'b0, '0, csr_pkg::CSR_MTVEC, '0);

        // Write and read back
        commit_instr(commit_pkg::OP_CSR_WRITE, 1'b0, '0, csr_pkg::CSR_MSCRATCH, rand_bits(32));
        commit_instr(commit_pkg::OP_CSR_READ, 1'b0, '0, csr_pkg::CSR_MSCRATCH, '0);
        commit_instr(commit_pkg::OP_CSR_WRITE, 1'b0, '0, csr_pkg::CSR_MTVEC, rand_bits(32));
        commit_instr(commit_pkg::OP_CSR_READ, 1'b0, '0, csr_pkg::CSR_MTVEC, '0);

        // Upstream exception, then mepc and mcause
        r = rand_bits(4);
        commit_instr(commit_pkg::OP_NONE, 1'b1, r[3:0], '0, '0);
        commit_instr(commit_pkg::OP_CSR_READ, 1'b0, '0, csr_pkg::CSR_MEPC, '0);
        commit_instr(commit_pkg::OP_CSR_READ, 1'b0, '0, csr_pkg::CSR_MCAUSE, '0);

        // Return from trap
        commit_instr(commit_pkg::OP_CSR_WRITE, 1'b0, '0, csr_pkg::CSR_MEPC, rand_bits(32));
        commit_instr(commit_pkg::OP_ERET, 1'b0, '0, '0, '0);
        commit_instr(commit_pkg::OP_CSR_READ, 1'b0, '0, csr_pkg::CSR_MEPC, '0);

        // Illegal accesses leave state alone
        commit_instr(commit_pkg::OP_CSR_WRITE, 1'b0, '0, csr_pkg::CSR_MINSTRET, rand_bits(32));
        commit_instr(commit_pkg::OP_CSR_READ, 1'b0, '0, csr_pkg::CSR_MINSTRET, '0);
        commit_instr(commit_pkg::OP_CSR_WRITE, 1'b0, '0, ADDR_UNKNOWN, rand_bits(32));
        commit_instr(commit_pkg::OP_CSR_READ, 1'b0, '0, ADDR_UNKNOWN, '0);
        commit_instr(commit_pkg::OP_CSR_READ, 1'b0, '0, csr_pkg::CSR_MCAUSE, '0);
        commit_instr(commit_pkg::OP_CSR_READ, 1'b0, '0, csr_pkg::CSR_MSCRATCH, '0);

        // Random retire mix with gaps, about one in four traps
        for (int i = 0; i < MIX_COUNT; i++) begin
            r = rand_bits(6);
            commit_instr(commit_pkg::OP_NONE, r[1:0] == 2'b11, r[5:2], '0, '0);
            idle(int'(rand_bits(2)));
        end
        commit_instr(commit_pkg::OP_CSR_READ, 1'b0, '0, csr_pkg::CSR_MINSTRET, '0);
        commit_instr(commit_pkg::OP_CSR_READ, 1'b0, '0, csr_pkg::CSR_MEXCNT, '0);

        drain();
        -> run_end;
    end

    initial begin
        @(run_end);
        $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== project.f ====
design/commit_pkg.sv
design/csr_pkg.sv
design/commit_ctrl_fsm.sv
design/flush_timer.sv
design/csr_regfile.sv
design/perf_counters.sv
design/commit_unit.sv
verif/commit_assertions.sv
verif/commit_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vcommit_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): project.f $(wildcard design/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f project.f --top-module commit_tb -o Vcommit_tb

# Pass or fail is judged from the log
run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^All tests passed!$$" sim.log

clean:
	rm -rf obj_dir sim.log
